//--- verilog.f
logic/pingpong_pkg.sv
logic/pingpong_bank_pair.sv
logic/pingpong_fill_ctrl.sv
logic/pingpong_drain_ctrl.sv
logic/pingpong_buffer.sv
bench/tb_clock_gen.sv
bench/pingpong_checker.sv
bench/pingpong_assert.sv
bench/tb_pingpong.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_pingpong
FILELIST  := verilog.f
OBJDIR    := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJDIR)

//--- bench/tb_pingpong.sv
/* Testbench top for the ping-pong buffer, DUT, stimulus on both streams,
   seeding, watchdog and the closing report */
module tb_pingpong;

    timeunit 1ns;
    timeprecision 100ps;

    import pingpong_pkg::*;

    localparam int unsigned SEED    = 32'hd4c8_110f;
    localparam int NUM_BLOCKS       = 12;
    localparam int BLOCK            = int'(DEPTH);
    localparam int NUM_SAMPLES      = NUM_BLOCKS * BLOCK;
    localparam int WR_GAP_PCT       = 25;      // Chance of an idle write cycle
    localparam int RD_GAP_PCT       = 20;      // Chance of a reader pause, first phase
    localparam int TIMEOUT_CYCLES   = NUM_BLOCKS * 2 * BLOCK * 8;

    logic    clk;
    logic    rst_n;
    logic    write_valid;
    sample_t write_data;
    logic    write_ready;
    logic    read_valid;
    sample_t read_data;
    logic    read_ready;
    logic    buffer_ready;
    int      phase;         // 0 free-running reader, 1 long stalls
    logic    done;
    int      reads_done;
    int      data_errs;
    int      ctrl_errs;

    tb_clock_gen u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    pingpong_buffer dut_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .write_valid_i  (write_valid),
        .write_data_i   (write_data),
        .write_ready_o  (write_ready),
        .read_valid_o   (read_valid),
        .read_data_o    (read_data),
        .read_ready_i   (read_ready),
        .buffer_ready_o (buffer_ready)
    );

    pingpong_checker u_checker (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .phase_i        (phase),
        .done_i         (done),
        .write_valid_i  (write_valid),
        .write_ready_i  (write_ready),
        .write_data_i   (write_data),
        .read_valid_i   (read_valid),
        .read_ready_i   (read_ready),
        .read_data_i    (read_data),
        .buffer_ready_i (buffer_ready),
        .reads_o        (reads_done),
        .data_errs_o    (data_errs),
        .ctrl_errs_o    (ctrl_errs)
    );

    bind pingpong_drain_ctrl pingpong_assert u_assert (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .read_ready_i   (read_ready_i),
        .read_valid_i   (read_valid_o),
        .buffer_ready_i (buffer_ready_o)
    );

    // ====================
    // Stimulus
    // ====================

    // Ready only moves at rising edges, so it is safe to look at here
    task automatic write_stream();
        sample_t data;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            data = sample_t'($urandom);
            while ($urandom_range(99) < WR_GAP_PCT) begin
                write_valid = 1'b0;
                @(negedge clk);
            end
            write_valid = 1'b1;
            write_data  = data;
            while (!write_ready) begin
                @(negedge clk);     // Hold data while the buffer is full
            end
            @(negedge clk);         // Accepted at the rising edge in between
        end
        write_valid = 1'b0;
    endtask

    task automatic read_stream();
        int start;
        while (reads_done < NUM_SAMPLES) begin
            if (phase == 0 && reads_done >= NUM_SAMPLES / 2) begin
                phase = 1;
            end
            if (phase == 0) begin
                read_ready = ($urandom_range(99) >= RD_GAP_PCT);
                @(negedge clk);
            end else begin
                // Long stall lets the writer fill both banks
                read_ready = 1'b0;
                repeat ($urandom_range(5 * BLOCK, 3 * BLOCK)) @(negedge clk);
                read_ready = 1'b1;
                start      = reads_done;
                if ($urandom_range(1) == 1) begin
                    do begin
                        @(negedge clk);     // Run on to the next block boundary
                    end while ((reads_done == start || reads_done % BLOCK != 0)
                               && reads_done < NUM_SAMPLES);
                end else begin
                    repeat ($urandom_range(BLOCK, 4)) @(negedge clk);
                end
            end
        end
        read_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        write_valid = 1'b0;
        write_data  = '0;
        read_ready  = 1'b0;
        phase       = 0;
        done        = 1'b0;
        wait (rst_n);
        @(negedge clk);
        fork
            write_stream();
            read_stream();
        join
        repeat (4) @(negedge clk);      // Last read valid fall gets checked
        done = 1'b1;
        repeat (2) @(negedge clk);
        $display("Errors: %0d data, %0d control", data_errs, ctrl_errs);
        if (data_errs + ctrl_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the streams never completed", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- bench/pingpong_assert.sv
/* Protocol assertions on the drain controller, read valid hold
   and the block-ready pulse shape */
module pingpong_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic read_ready_i,
    input logic read_valid_i,
    input logic buffer_ready_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Valid stays up until the reader takes the sample
    valid_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        read_valid_i && !read_ready_i |=> read_valid_i)
        else $error("read valid dropped without a transfer");

    pulse_single_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        buffer_ready_i |=> !buffer_ready_i)
        else $error("buffer ready high on two cycles in a row");

    pulse_on_rise_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        buffer_ready_i |-> $rose(read_valid_i))
        else $error("buffer ready without read valid rising");

endmodule

//--- bench/pingpong_checker.sv
/* Stream monitor for the ping-pong buffer with the reference model,
   per-edge comparisons and the error counters */
module pingpong_checker (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  int                    phase_i,          // 0 free-running reader, 1 stalled reader
    input  logic                  done_i,           // Stimulus finished, run end checks
    input  logic                  write_valid_i,
    input  logic                  write_ready_i,
    input  pingpong_pkg::sample_t write_data_i,
    input  logic                  read_valid_i,
    input  logic                  read_ready_i,
    input  pingpong_pkg::sample_t read_data_i,
    input  logic                  buffer_ready_i,
    output int                    reads_o,          // Read transfers seen so far
    output int                    data_errs_o,      // Wrong read samples
    output int                    ctrl_errs_o       // Handshake and pulse faults
);

    timeunit 1ns;
    timeprecision 100ps;

    import pingpong_pkg::*;

    localparam int BLOCK = int'(DEPTH);

    sample_t write_q [$];   // Every accepted write in order
    int      writes;        // Accepted writes
    int      pulses;        // Block-ready pulses seen before this edge
    int      peak;          // Most samples stored and unread at once
    logic    valid_q;       // Read valid at the previous edge
    logic    final_done;

    function automatic string test_name(input int phase);
        return (phase == 0) ? "free_run" : "stalled_reader";
    endfunction

    // Reference model
    // Next read is the oldest unread write, announced blocks are the full ones
    function automatic int reference_model(input int n_writes, input int n_reads,
                                           output sample_t next_sample);
        next_sample = (n_reads < write_q.size()) ? write_q[n_reads] : '0;
        return n_writes / BLOCK;
    endfunction

    // Inputs change on falling edges, so everything is stable here
    always @(posedge clk_i) begin : monitor
        sample_t exp_sample;
        int      exp_blocks;
        int      level;
        if (!rst_ni) begin
            write_q.delete();
            writes      = 0;
            pulses      = 0;
            peak        = 0;
            valid_q     = 1'b0;
            final_done  = 1'b0;
            reads_o     = 0;
            data_errs_o = 0;
            ctrl_errs_o = 0;
        end else begin
            exp_blocks = reference_model(writes, reads_o, exp_sample);
            level      = writes - (pulses + int'(buffer_ready_i)) * BLOCK;  // Write bank fill

            if (write_ready_i !== (level < BLOCK)) begin
                $display("[%s] write_ready_o is %b with %0d samples in the write bank",
                         test_name(phase_i), write_ready_i, level);
                ctrl_errs_o++;
            end

            // ====================
            // Block announce
            // ====================
            if (buffer_ready_i) begin
                if (!read_valid_i || valid_q) begin
                    $display("[%s] buffer_ready_o did not line up with read_valid_o rising",
                             test_name(phase_i));
                    ctrl_errs_o++;
                end
                if (reads_o != pulses * BLOCK) begin   // Swap overtook a drain
                    $display("[%s] new block announced after only %0d of %0d reads",
                             test_name(phase_i), reads_o, pulses * BLOCK);
                    ctrl_errs_o++;
                end
                if (exp_blocks != pulses + 1) begin
                    $display("** Error [%s] block count expected %0d actual %0d",
                             test_name(phase_i), exp_blocks, pulses + 1);
                    ctrl_errs_o++;
                end
                pulses++;
            end else if (read_valid_i && !valid_q) begin
                $display("[%s] read_valid_o rose without a buffer_ready_o pulse",
                         test_name(phase_i));
                ctrl_errs_o++;
            end
            if (valid_q && !read_valid_i && reads_o != pulses * BLOCK) begin
                $display("[%s] read_valid_o fell with the block only partly read",
                         test_name(phase_i));
                ctrl_errs_o++;
            end

            // ====================
            // Transfers
            // ====================
            if (read_valid_i && read_ready_i) begin
                if (reads_o >= pulses * BLOCK) begin
                    $display("[%s] read transfer past the end of the announced block",
                             test_name(phase_i));
                    ctrl_errs_o++;
                end else if (read_data_i !== exp_sample) begin
                    $display("** Error [%s] read %0d expected %h actual %h",
                             test_name(phase_i), reads_o, exp_sample, read_data_i);
                    data_errs_o++;
                end
                reads_o++;
            end
            if (write_valid_i && write_ready_i) begin
                write_q.push_back(write_data_i);
                writes++;
            end
            if (writes - reads_o > peak) begin
                peak = writes - reads_o;
            end

            // End of run, every sample back out and both banks filled once
            if (done_i && !final_done) begin
                final_done = 1'b1;
                if (writes != reads_o) begin
                    $display("%0d samples were written but %0d were read", writes, reads_o);
                    ctrl_errs_o++;
                end
                if (peak != 2 * BLOCK) begin
                    $display("Stored samples peaked at %0d instead of two full banks", peak);
                    ctrl_errs_o++;
                end
            end
            valid_q = read_valid_i;
        end
    end

endmodule

//--- bench/tb_clock_gen.sv
/* Testbench clock and reset source, 20 ns period, reset low for 5 cycles */
module tb_clock_gen (
    output logic clk_o,     // Free-running clock
    output logic rst_no     // Synchronous reset, active low
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;     // Half of the 20 ns period
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- logic/pingpong_buffer.sv
/* Ping-pong sample buffer top level, fill and drain controllers
   around the bank pair */
module pingpong_buffer (
    input  logic                  clk_i,            // System clock
    input  logic                  rst_ni,           // Synchronous reset, active low
    // Write stream
    input  logic                  write_valid_i,    // Writer offers a sample
    input  pingpong_pkg::sample_t write_data_i,     // Offered sample
    output logic                  write_ready_o,    // Write bank has room
    // Read stream
    output logic                  read_valid_o,     // Sample available
    output pingpong_pkg::sample_t read_data_o,      // Sample, meaningful while valid
    input  logic                  read_ready_i,     // Reader takes the sample
    // Status
    output logic                  buffer_ready_o    // Pulse, a new block is readable
);

    import pingpong_pkg::*;

    // ====================
    // Internal wires
    // ====================

    bank_wr_t bank_wr;  // Fill side into the banks
    addr_t    rd_addr;  // Drain side into the banks
    logic     swap;     // Swap strobe from fill to drain side

    // ====================
    // Write side
    // ====================

    pingpong_fill_ctrl u_fill_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_valid_i (write_valid_i),
        .write_data_i  (write_data_i),
        .drain_busy_i  (read_valid_o),      // Reader busy while valid is up
        .write_ready_o (write_ready_o),
        .bank_wr_o     (bank_wr),
        .swap_o        (swap)
    );

    // ====================
    // Read side
    // ====================

    pingpong_drain_ctrl u_drain_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .swap_i         (swap),
        .read_ready_i   (read_ready_i),
        .read_valid_o   (read_valid_o),
        .rd_addr_o      (rd_addr),
        .buffer_ready_o (buffer_ready_o)
    );

    // ====================
    // Storage
    // ====================

    pingpong_bank_pair #(
        .payload_t (sample_t)
    ) u_bank_pair (
        .clk_i     (clk_i),
        .bank_wr_i (bank_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (read_data_o)            // Opposite bank, combinational
    );

endmodule

//--- logic/pingpong_drain_ctrl.sv
/* Read-side handshake, drain counter, read valid
   and the block-ready pulse */
module pingpong_drain_ctrl (
    input  logic                clk_i,          // System clock
    input  logic                rst_ni,         // Synchronous reset, active low
    input  logic                swap_i,         // Banks swap at this edge
    input  logic                read_ready_i,   // Reader takes a sample
    output logic                read_valid_o,   // Read bank holds unread samples
    output pingpong_pkg::addr_t rd_addr_o,      // Slot to read next
    output logic                buffer_ready_o  // One-cycle new block pulse
);

    import pingpong_pkg::*;

    // ====================
    // State
    // ====================

    count_t drain_cnt_q;    // Samples already taken from the read bank
    count_t drain_cnt_nx;   // Level after the current transfer
    logic   valid_q;        // Read valid register
    logic   pulse_q;        // Block-ready register
    logic   transfer;       // Handshake completes this cycle
    logic   last_xfer;      // Transfer takes the final sample

    // ====================
    // Handshake
    // ====================

    assign transfer     = valid_q && read_ready_i;
    assign drain_cnt_nx = drain_cnt_q + count_t'(1);
    assign last_xfer    = transfer && (drain_cnt_nx == BLOCK_CNT);

    // Address is the low part of the drain level
    assign rd_addr_o      = drain_cnt_q[ADDR_W-1:0];
    assign read_valid_o   = valid_q;
    assign buffer_ready_o = pulse_q;

    // ====================
    // Drain sequence
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q     <= 1'b0;
            pulse_q     <= 1'b0;
            drain_cnt_q <= '0;
        end else begin
            pulse_q <= swap_i;              // High for the cycle after the swap

            if (swap_i) begin
                // Fresh block, begin at slot 0
                valid_q     <= 1'b1;
                drain_cnt_q <= '0;
            end else if (transfer) begin
                drain_cnt_q <= drain_cnt_nx;
                if (last_xfer) begin
                    valid_q <= 1'b0;        // Bank empty, hand it back
                end
            end
        end
    end

    // Swap needs valid low, so it never overlaps a transfer
    // Valid and address hold while the reader stalls

endmodule

//--- logic/pingpong_fill_ctrl.sv
/* Write-side handshake, fill counter, write bank select
   and the swap decision */
module pingpong_fill_ctrl (
    input  logic                   clk_i,           // System clock
    input  logic                   rst_ni,          // Synchronous reset, active low
    input  logic                   write_valid_i,   // Writer offers a sample
    input  pingpong_pkg::sample_t  write_data_i,    // Offered sample
    input  logic                   drain_busy_i,    // Reader still owns its bank
    output logic                   write_ready_o,   // Room left in write bank
    output pingpong_pkg::bank_wr_t bank_wr_o,       // Write into the bank pair
    output logic                   swap_o           // One-cycle bank swap strobe
);

    import pingpong_pkg::*;

    // ====================
    // State
    // ====================

    count_t fill_cnt_q;     // Samples held in the write bank
    logic   bank_sel_q;     // Bank currently being filled
    logic   write_accept;   // Handshake completes this cycle
    logic   bank_full;      // Write bank holds a whole block

    // ====================
    // Handshake
    // ====================

    // Ready straight from the count, no registered stage
    assign bank_full     = (fill_cnt_q == BLOCK_CNT);
    assign write_ready_o = (fill_cnt_q < BLOCK_CNT);
    assign write_accept  = write_valid_i && write_ready_o;

    // Swap only once the reader has let go of the other bank,
    // otherwise an unread block would be overwritten
    assign swap_o = bank_full && !drain_busy_i;

    // ====================
    // Bank write
    // ====================

    // Address follows the fill level, data passes through unregistered
    always_comb begin
        bank_wr_o.we   = write_accept;
        bank_wr_o.bank = bank_sel_q;
        bank_wr_o.addr = fill_cnt_q[ADDR_W-1:0];
        bank_wr_o.data = write_data_i;
    end

    // ====================
    // Counter and select
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            fill_cnt_q <= '0;
            bank_sel_q <= 1'b0;             // Start filling bank 0
        end else if (swap_o) begin
            // Full bank goes to the reader, start fresh in the other one
            fill_cnt_q <= '0;
            bank_sel_q <= ~bank_sel_q;
        end else if (write_accept) begin
            fill_cnt_q <= fill_cnt_q + count_t'(1);
        end
    end

    // Note: swap and accept never meet, a full bank drops write_ready_o

endmodule

//--- logic/pingpong_bank_pair.sv
/* Two storage banks, one write port steered by the bank select,
   one combinational read port on the opposite bank */
module pingpong_bank_pair #(
    parameter type payload_t = pingpong_pkg::sample_t   // Stored entry type
) (
    input  logic                   clk_i,       // System clock
    input  pingpong_pkg::bank_wr_t bank_wr_i,   // Write strobe, bank, address, data
    input  pingpong_pkg::addr_t    rd_addr_i,   // Read slot in the other bank
    output payload_t               rd_data_o    // Entry at rd_addr_i
);

    import pingpong_pkg::*;

    // ====================
    // Storage
    // ====================

    payload_t bank_rd [2];  // Read word from each bank
    payload_t wr_word;      // Incoming sample in storage format

    assign wr_word = payload_t'(bank_wr_i.data);

    // One bank per generate pass, each with its own array
    for (genvar b = 0; b < 2; b++) begin : g_bank
        payload_t mem [DEPTH];  // No reset, contents are payload only
        logic     bank_we;      // Strobe for this bank only

        assign bank_we = bank_wr_i.we && (bank_wr_i.bank == 1'(b));

        // Write lands at the edge
        always_ff @(posedge clk_i) begin
            if (bank_we) begin
                mem[bank_wr_i.addr] <= wr_word;
            end
        end

        // Asynchronous read, same address into both banks
        assign bank_rd[b] = mem[rd_addr_i];
    end

    // ====================
    // Read select
    // ====================

    // Reader always sees the bank that is not being filled
    always_comb begin
        if (bank_wr_i.bank) begin
            rd_data_o = bank_rd[0];     // Writing bank 1, read bank 0
        end else begin
            rd_data_o = bank_rd[1];     // Writing bank 0, read bank 1
        end
    end

endmodule

//--- logic/pingpong_pkg.sv
/* Shared sizes, sample/address/count types and the bank write struct
   for the ping-pong sample buffer */
package pingpong_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int unsigned DATA_W  = 32;               // Sample width in bits
    localparam int unsigned DEPTH   = 16;               // Samples per bank
    localparam int unsigned ADDR_W  = $clog2(DEPTH);    // Address bits for one bank
    localparam int unsigned COUNT_W = ADDR_W + 1;       // Extra bit so DEPTH fits

    // ====================
    // Types
    // ====================

    // Signed stream sample
    typedef logic signed [DATA_W-1:0] sample_t;

    // Location inside one bank
    typedef logic [ADDR_W-1:0] addr_t;

    // Fill or drain level, 0 up to DEPTH inclusive
    typedef logic [COUNT_W-1:0] count_t;

    // Count value of a complete block
    localparam count_t BLOCK_CNT = count_t'(DEPTH);

    // One write into the bank pair
    // The bank field also tells the pair which bank is free for reading
    typedef struct packed {
        logic    we;    // Write strobe
        logic    bank;  // Current write bank
        addr_t   addr;  // Slot in that bank
        sample_t data;  // Sample to store
    } bank_wr_t;

endpackage
